//--- ntm_input_gate.f
+incdir+.
ntm_pkg.sv
ntm_operand_memory.sv
ntm_dot_product.sv
ntm_logistic_function.sv
ntm_input_gate_vector.sv
ntm_input_gate_top.sv
ntm_input_gate_tb.sv

//--- Bender.yml
package:
  name: ntm_input_gate

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ntm_pkg.sv
      - ntm_operand_memory.sv
      - ntm_dot_product.sv
      - ntm_logistic_function.sv
      - ntm_input_gate_vector.sv
      - ntm_input_gate_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - ntm_input_gate_tb.sv

//--- ntm_input_gate_tb.sv
`timescale 1ns/10ps
`include "ntm_defs.svh"

module ntm_input_gate_tb;
  import ntm_pkg::*;

  // Sum over all runs of L*(X+W+L+4)
  localparam int RUN_CYCLES = 1 * (1 + 1 + 1 + 4) + 4 * (4 + 4 + 4 + 4)
                            + 4 * (3 + 5 + 4 + 4) + 5 * (2 + 1 + 5 + 4)
                            + 2 * 8 * (8 + 8 + 8 + 4) + 3 * (2 + 2 + 3 + 4);
  // One cycle per loaded element
  localparam int LOAD_CYCLES    = 32 + 64 + 23 + 224 + 8;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + LOAD_CYCLES + 200;

  logic                        CLK = 1'b0;
  logic                        RST;
  logic                        LOAD_ENABLE;
  ntm_operand_t                LOAD_SELECT;
  logic [`NTM_INDEX_BITS-1:0]  LOAD_ROW;
  logic [`NTM_INDEX_BITS-1:0]  LOAD_COLUMN;
  logic [`NTM_DATA_SIZE-1:0]   LOAD_DATA;
  logic [`NTM_SIZE_BITS-1:0]   SIZE_X_IN;
  logic [`NTM_SIZE_BITS-1:0]   SIZE_W_IN;
  logic [`NTM_SIZE_BITS-1:0]   SIZE_L_IN;
  logic                        START;
  logic                        I_OUT_ENABLE;
  logic [`NTM_DATA_SIZE-1:0]   I_OUT;
  logic                        READY;

  // Reference copy of the operand store
  logic signed [`NTM_DATA_SIZE-1:0] w_model [0:`NTM_MAX_L-1][0:`NTM_MAX_X-1];
  logic signed [`NTM_DATA_SIZE-1:0] k_model [0:`NTM_MAX_L-1][0:`NTM_MAX_W-1];
  logic signed [`NTM_DATA_SIZE-1:0] u_model [0:`NTM_MAX_L-1][0:`NTM_MAX_L-1];
  logic signed [`NTM_DATA_SIZE-1:0] x_model [0:`NTM_MAX_X-1];
  logic signed [`NTM_DATA_SIZE-1:0] r_model [0:`NTM_MAX_W-1];
  logic signed [`NTM_DATA_SIZE-1:0] h_model [0:`NTM_MAX_L-1];
  logic signed [`NTM_DATA_SIZE-1:0] b_model [0:`NTM_MAX_L-1];

  // Gate values of the last run, in order
  logic [`NTM_DATA_SIZE-1:0] out_q [$];
  integer                    seed;
  int                        cycle_count = 0;

  ntm_input_gate_top i_dut (
    .CLK          (CLK),
    .RST          (RST),
    .LOAD_ENABLE  (LOAD_ENABLE),
    .LOAD_SELECT  (LOAD_SELECT),
    .LOAD_ROW     (LOAD_ROW),
    .LOAD_COLUMN  (LOAD_COLUMN),
    .LOAD_DATA    (LOAD_DATA),
    .SIZE_X_IN    (SIZE_X_IN),
    .SIZE_W_IN    (SIZE_W_IN),
    .SIZE_L_IN    (SIZE_L_IN),
    .START        (START),
    .I_OUT_ENABLE (I_OUT_ENABLE),
    .I_OUT        (I_OUT),
    .READY        (READY)
  );

  always #5 CLK = ~CLK;

  // Run limit
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
      $display("Test failures found");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Small signed Q8.8 value, about -1.0 to +1.0
  function automatic logic [`NTM_DATA_SIZE-1:0] rand_word();
    int value;
    value = $random(seed) % 256;
    return value[`NTM_DATA_SIZE-1:0];
  endfunction

  // One write per cycle, model follows the DUT store
  task automatic load_element(ntm_operand_t sel, int row, int col, int data);
    @(posedge CLK);
    LOAD_ENABLE <= 1'b1;
    LOAD_SELECT <= sel;
    LOAD_ROW    <= row[`NTM_INDEX_BITS-1:0];
    LOAD_COLUMN <= col[`NTM_INDEX_BITS-1:0];
    LOAD_DATA   <= data[`NTM_DATA_SIZE-1:0];
    case (sel)
      OPERAND_W: w_model[row][col] = data[`NTM_DATA_SIZE-1:0];
      OPERAND_K: k_model[row][col] = data[`NTM_DATA_SIZE-1:0];
      OPERAND_U: u_model[row][col] = data[`NTM_DATA_SIZE-1:0];
      OPERAND_X: x_model[col] = data[`NTM_DATA_SIZE-1:0];
      OPERAND_R: r_model[col] = data[`NTM_DATA_SIZE-1:0];
      OPERAND_H: h_model[col] = data[`NTM_DATA_SIZE-1:0];
      default:   b_model[col] = data[`NTM_DATA_SIZE-1:0];
    endcase
  endtask

  // Saturate to one signed 16-bit word
  function automatic longint clip_word(longint v);
    if (v > 32767) begin
      return 32767;
    end else if (v < -32768) begin
      return -32768;
    end
    return v;
  endfunction

  // Gate value of one row from the model arrays
  function automatic int expected_gate(int row, int sx, int sw, int sl);
    longint sum;
    longint z;
    longint g;
    int     j;
    sum = 0;
    for (j = 0; j < sx; j++) sum += longint'(w_model[row][j]) * longint'(x_model[j]);
    for (j = 0; j < sw; j++) sum += longint'(k_model[row][j]) * longint'(r_model[j]);
    for (j = 0; j < sl; j++) sum += longint'(u_model[row][j]) * longint'(h_model[j]);
    z = clip_word(sum >>> `NTM_FRAC_BITS);
    z = clip_word(z + longint'(b_model[row]));
    // Hard sigmoid, 0.5 is 128 and 1.0 is 256
    g = (z >>> 2) + 128;
    if (g < 0) g = 0;
    if (g > 256) g = 256;
    return int'(g);
  endfunction

  // START, collect outputs until READY, compare, then watch for stray strobes
  task automatic run_gate(int sx, int sw, int sl, int restart_at, int watch_cycles);
    int n;
    int i;
    bit done;
    n = 0;
    done = 1'b0;
    out_q.delete();
    @(posedge CLK);
    SIZE_X_IN   <= sx[`NTM_SIZE_BITS-1:0];
    SIZE_W_IN   <= sw[`NTM_SIZE_BITS-1:0];
    SIZE_L_IN   <= sl[`NTM_SIZE_BITS-1:0];
    LOAD_ENABLE <= 1'b0;
    START       <= 1'b1;
    @(posedge CLK);
    START <= 1'b0;
    while (!done) begin
      @(negedge CLK);
      n++;
      if (I_OUT_ENABLE) out_q.push_back(I_OUT);
      if (READY) begin
        check_value("output count at READY", sl, out_q.size());
        done = 1'b1;
      end
      // Second START lands while the FSM is busy
      if (restart_at != 0 && n == restart_at) begin
        @(posedge CLK);
        START <= 1'b1;
      end else if (restart_at != 0 && n == restart_at + 1) begin
        @(posedge CLK);
        START <= 1'b0;
      end
    end
    for (i = 0; i < sl; i++) begin
      check_value($sformatf("I_OUT row %0d", i), expected_gate(i, sx, sw, sl), out_q[i]);
    end
    for (i = 0; i < watch_cycles; i++) begin
      @(negedge CLK);
      check_value("READY after done", 0, READY);
      check_value("I_OUT_ENABLE after done", 0, I_OUT_ENABLE);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_reset_state();
    repeat (8) begin
      @(negedge CLK);
      check_value("READY after reset", 0, READY);
      check_value("I_OUT_ENABLE after reset", 0, I_OUT_ENABLE);
      check_value("I_OUT after reset", 0, I_OUT);
    end
    // Zero store, one term of each product
    run_gate(1, 1, 1, 0, 2);
    check_value("I_OUT of zero sum", 128, out_q[0]);
  endtask

  // W.x path alone, last row clamps high
  task automatic test_identity_path();
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) load_element(OPERAND_W, i, j, (i == j) ? 16'h0100 : 0);
      load_element(OPERAND_R, 0, i, 0);
      load_element(OPERAND_H, 0, i, 0);
      load_element(OPERAND_B, 0, i, 0);
    end
    load_element(OPERAND_X, 0, 0, 16'h0040);
    load_element(OPERAND_X, 0, 1, 16'h0100);
    load_element(OPERAND_X, 0, 2, 16'hFF00);
    load_element(OPERAND_X, 0, 3, 16'h0A00);
    run_gate(4, 4, 4, 0, 2);
  endtask

  // Every path plus bias, no clamping
  task automatic test_full_products();
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 3; j++) load_element(OPERAND_W, i, j, (i - j) * 32);
      for (int j = 0; j < 5; j++) load_element(OPERAND_K, i, j, (j - i + 1) * 16);
      for (int j = 0; j < 4; j++) load_element(OPERAND_U, i, j, 24 * (i + 1) - 8 * j);
      load_element(OPERAND_H, 0, i, -64 + 40 * i);
      load_element(OPERAND_B, 0, i, 50 * i - 75);
    end
    for (int j = 0; j < 3; j++) load_element(OPERAND_X, 0, j, (j + 1) * 64);
    for (int j = 0; j < 5; j++) load_element(OPERAND_R, 0, j, 128 - 48 * j);
    run_gate(3, 5, 4, 0, 2);
  endtask

  // Sum saturation, then bias overflow in both directions
  task automatic test_saturation();
    load_element(OPERAND_W, 0, 0, 16'h7FFF);
    load_element(OPERAND_W, 0, 1, 16'h7FFF);
    load_element(OPERAND_W, 1, 0, 16'h8000);
    load_element(OPERAND_W, 1, 1, 16'h8000);
    load_element(OPERAND_W, 2, 0, 16'h7FFF);
    load_element(OPERAND_W, 2, 1, 0);
    load_element(OPERAND_W, 3, 0, 16'h00E0);
    load_element(OPERAND_W, 3, 1, 0);
    load_element(OPERAND_W, 4, 0, 16'hFF20);
    load_element(OPERAND_W, 4, 1, 0);
    load_element(OPERAND_X, 0, 0, 16'h7FFF);
    load_element(OPERAND_X, 0, 1, 16'h7FFF);
    load_element(OPERAND_R, 0, 0, 0);
    for (int i = 0; i < 5; i++) load_element(OPERAND_H, 0, i, 0);
    load_element(OPERAND_B, 0, 0, 0);
    load_element(OPERAND_B, 0, 1, 0);
    load_element(OPERAND_B, 0, 2, 16'h8000);
    load_element(OPERAND_B, 0, 3, 16'h7000);
    load_element(OPERAND_B, 0, 4, 16'h9000);
    run_gate(2, 1, 5, 0, 2);
  endtask

  // Full size, then a rerun with new h only
  task automatic test_random_runs();
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 8; j++) begin
        load_element(OPERAND_W, i, j, rand_word());
        load_element(OPERAND_K, i, j, rand_word());
        load_element(OPERAND_U, i, j, rand_word());
      end
      load_element(OPERAND_X, 0, i, rand_word());
      load_element(OPERAND_R, 0, i, rand_word());
      load_element(OPERAND_H, 0, i, rand_word());
      load_element(OPERAND_B, 0, i, rand_word());
    end
    run_gate(8, 8, 8, 0, 2);
    for (int i = 0; i < 8; i++) load_element(OPERAND_H, 0, i, rand_word());
    run_gate(8, 8, 8, 0, 2);
  endtask

  // START during the K.r and U.h terms of row 0 must be ignored
  task automatic test_busy_start();
    run_gate(2, 2, 3, 3, 40);
  endtask

  initial begin
    seed = 32'h6c7b;
    for (int i = 0; i < `NTM_MAX_L; i++) begin
      for (int j = 0; j < 8; j++) begin
        w_model[i][j] = '0;
        k_model[i][j] = '0;
        u_model[i][j] = '0;
      end
      x_model[i] = '0;
      r_model[i] = '0;
      h_model[i] = '0;
      b_model[i] = '0;
    end
    RST         <= 1'b1;
    LOAD_ENABLE <= 1'b0;
    LOAD_SELECT <= OPERAND_W;
    LOAD_ROW    <= '0;
    LOAD_COLUMN <= '0;
    LOAD_DATA   <= '0;
    SIZE_X_IN   <= 4'd1;
    SIZE_W_IN   <= 4'd1;
    SIZE_L_IN   <= 4'd1;
    START       <= 1'b0;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    test_reset_state();
    test_identity_path();
    test_full_products();
    test_saturation();
    test_random_runs();
    test_busy_start();

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- ntm_input_gate_top.sv
`timescale 1ns/10ps
`include "ntm_defs.svh"

module ntm_input_gate_top (
  input  logic                              CLK,
  input  logic                              RST,
  // Operand loading
  input  logic                              LOAD_ENABLE,
  input  ntm_pkg::ntm_operand_t             LOAD_SELECT,
  input  logic [`NTM_INDEX_BITS-1:0]        LOAD_ROW,
  input  logic [`NTM_INDEX_BITS-1:0]        LOAD_COLUMN,
  input  logic [`NTM_DATA_SIZE-1:0]         LOAD_DATA,
  // Dimensions
  input  logic [`NTM_SIZE_BITS-1:0]         SIZE_X_IN,
  input  logic [`NTM_SIZE_BITS-1:0]         SIZE_W_IN,
  input  logic [`NTM_SIZE_BITS-1:0]         SIZE_L_IN,
  // Control and result
  input  logic                              START,
  output logic                              I_OUT_ENABLE,
  output logic [`NTM_DATA_SIZE-1:0]         I_OUT,
  output logic                              READY
);
  import ntm_pkg::*;

  // Memory read side
  ntm_operand_t                      matrix_select;
  ntm_operand_t                      vector_select;
  logic [`NTM_INDEX_BITS-1:0]        matrix_row;
  logic [`NTM_INDEX_BITS-1:0]        matrix_column;
  logic [`NTM_INDEX_BITS-1:0]        vector_index;
  logic [`NTM_INDEX_BITS-1:0]        bias_index;
  logic signed [`NTM_DATA_SIZE-1:0]  matrix_data;
  logic signed [`NTM_DATA_SIZE-1:0]  vector_data;
  logic signed [`NTM_DATA_SIZE-1:0]  bias_data;

  // Accumulator
  logic                              mac_clear;
  logic                              mac_issue;
  logic signed [`NTM_ACC_SIZE-1:0]   accumulator;

  // Logistic stage
  logic                              logistic_start;
  logic [`NTM_DATA_SIZE-1:0]         logistic_out;
  logic                              logistic_valid;

  ntm_operand_memory operand_memory (
    .CLK           (CLK),
    .RST           (RST),
    .load_enable   (LOAD_ENABLE),
    .load_select   (LOAD_SELECT),
    .load_row      (LOAD_ROW),
    .load_column   (LOAD_COLUMN),
    .load_data     (LOAD_DATA),
    .matrix_select (matrix_select),
    .matrix_row    (matrix_row),
    .matrix_column (matrix_column),
    .matrix_data   (matrix_data),
    .vector_select (vector_select),
    .vector_index  (vector_index),
    .vector_data   (vector_data),
    .bias_index    (bias_index),
    .bias_data     (bias_data)
  );

  // Shared MAC for all three products
  ntm_dot_product dot_product (
    .CLK         (CLK),
    .RST         (RST),
    .mac_clear   (mac_clear),
    .mac_issue   (mac_issue),
    .operand_a   (matrix_data),
    .operand_b   (vector_data),
    .accumulator (accumulator)
  );

  ntm_logistic_function logistic_function (
    .CLK            (CLK),
    .RST            (RST),
    .logistic_start (logistic_start),
    .accumulator    (accumulator),
    .bias           (bias_data),
    .logistic_out   (logistic_out),
    .logistic_valid (logistic_valid)
  );

  ntm_input_gate_vector input_gate_vector (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .SIZE_X_IN      (SIZE_X_IN),
    .SIZE_W_IN      (SIZE_W_IN),
    .SIZE_L_IN      (SIZE_L_IN),
    .matrix_select  (matrix_select),
    .matrix_row     (matrix_row),
    .matrix_column  (matrix_column),
    .vector_select  (vector_select),
    .vector_index   (vector_index),
    .bias_index     (bias_index),
    .mac_clear      (mac_clear),
    .mac_issue      (mac_issue),
    .logistic_start (logistic_start),
    .logistic_out   (logistic_out),
    .logistic_valid (logistic_valid),
    .I_OUT_ENABLE   (I_OUT_ENABLE),
    .I_OUT          (I_OUT)
  );

endmodule

//--- ntm_input_gate_vector.sv
`timescale 1ns/10ps
`include "ntm_defs.svh"

module ntm_input_gate_vector (
  input  logic                              CLK,
  input  logic                              RST,
  // Control
  input  logic                              START,
  output logic                              READY,
  // Dimensions, stable while busy
  input  logic [`NTM_SIZE_BITS-1:0]         SIZE_X_IN,
  input  logic [`NTM_SIZE_BITS-1:0]         SIZE_W_IN,
  input  logic [`NTM_SIZE_BITS-1:0]         SIZE_L_IN,
  // Operand memory addressing
  output ntm_pkg::ntm_operand_t             matrix_select,
  output logic [`NTM_INDEX_BITS-1:0]        matrix_row,
  output logic [`NTM_INDEX_BITS-1:0]        matrix_column,
  output ntm_pkg::ntm_operand_t             vector_select,
  output logic [`NTM_INDEX_BITS-1:0]        vector_index,
  output logic [`NTM_INDEX_BITS-1:0]        bias_index,
  // Accumulator strobes
  output logic                              mac_clear,
  output logic                              mac_issue,
  // Logistic stage
  output logic                              logistic_start,
  input  logic [`NTM_DATA_SIZE-1:0]         logistic_out,
  input  logic                              logistic_valid,
  // Gate result
  output logic                              I_OUT_ENABLE,
  output logic [`NTM_DATA_SIZE-1:0]         I_OUT
);
  import ntm_pkg::*;

  ntm_gate_state_t state;

  // Row and column position
  logic [`NTM_SIZE_BITS-1:0] row_count;
  logic [`NTM_SIZE_BITS-1:0] term_count;

  // Length of the product in flight
  logic [`NTM_SIZE_BITS-1:0] term_size;
  logic                      term_last;
  logic                      row_last;

  // Two cycle pipeline drain
  logic                      drain_count;

  ////////////////////
  // Sequencing helpers
  ////////////////////

  always_comb begin
    case (state)
      K_PRODUCT_STATE: term_size = SIZE_W_IN;
      U_PRODUCT_STATE: term_size = SIZE_L_IN;
      default:         term_size = SIZE_X_IN;
    endcase
  end

  assign term_last = (term_count == term_size - 1'b1);
  assign row_last  = (row_count == SIZE_L_IN - 1'b1);

  ////////////////////
  // Read addressing
  ////////////////////

  // W.x, then K.r, then U.h for the same row
  always_comb begin
    matrix_select = OPERAND_W;
    vector_select = OPERAND_X;
    mac_issue     = 1'b1;
    case (state)
      W_PRODUCT_STATE: begin
        matrix_select = OPERAND_W;
        vector_select = OPERAND_X;
      end
      K_PRODUCT_STATE: begin
        matrix_select = OPERAND_K;
        vector_select = OPERAND_R;
      end
      U_PRODUCT_STATE: begin
        matrix_select = OPERAND_U;
        vector_select = OPERAND_H;
      end
      default: mac_issue = 1'b0;
    endcase
  end

  assign matrix_row    = row_count[`NTM_INDEX_BITS-1:0];
  assign matrix_column = term_count[`NTM_INDEX_BITS-1:0];
  assign vector_index  = term_count[`NTM_INDEX_BITS-1:0];
  assign bias_index    = row_count[`NTM_INDEX_BITS-1:0];

  // Logistic takes the drained sum
  assign logistic_start = (state == LOGISTIC_STATE);

  // Empty the sum once the row result is out
  assign mac_clear = (state == OUTPUT_STATE) && logistic_valid;

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= STARTER_STATE;
      row_count    <= '0;
      term_count   <= '0;
      drain_count  <= 1'b0;
      I_OUT_ENABLE <= 1'b0;
      I_OUT        <= '0;
      READY        <= 1'b0;
    end else begin
      // Strobes last one cycle
      I_OUT_ENABLE <= 1'b0;
      READY        <= 1'b0;

      case (state)
        STARTER_STATE: begin
          if (START) begin
            row_count  <= '0;
            term_count <= '0;
            state      <= W_PRODUCT_STATE;
          end
        end

        W_PRODUCT_STATE: begin
          term_count <= term_count + 1'b1;
          if (term_last) begin
            term_count <= '0;
            state      <= K_PRODUCT_STATE;
          end
        end

        K_PRODUCT_STATE: begin
          term_count <= term_count + 1'b1;
          if (term_last) begin
            term_count <= '0;
            state      <= U_PRODUCT_STATE;
          end
        end

        U_PRODUCT_STATE: begin
          term_count <= term_count + 1'b1;
          if (term_last) begin
            term_count  <= '0;
            drain_count <= 1'b0;
            state       <= DRAIN_STATE;
          end
        end

        // Last two products reach the sum
        DRAIN_STATE: begin
          drain_count <= ~drain_count;
          if (drain_count) begin
            state <= LOGISTIC_STATE;
          end
        end

        LOGISTIC_STATE: state <= OUTPUT_STATE;

        OUTPUT_STATE: begin
          if (logistic_valid) begin
            I_OUT        <= logistic_out;
            I_OUT_ENABLE <= 1'b1;
            if (row_last) begin
              state <= ENDER_STATE;
            end else begin
              row_count <= row_count + 1'b1;
              state     <= W_PRODUCT_STATE;
            end
          end
        end

        // Done one cycle after the last result
        ENDER_STATE: begin
          READY <= 1'b1;
          state <= STARTER_STATE;
        end

        default: state <= STARTER_STATE;
      endcase
    end
  end

endmodule

//--- ntm_logistic_function.sv
`timescale 1ns/10ps
`include "ntm_defs.svh"

module ntm_logistic_function (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              logistic_start,
  input  logic signed [`NTM_ACC_SIZE-1:0]   accumulator,
  input  logic signed [`NTM_DATA_SIZE-1:0]  bias,
  output logic        [`NTM_DATA_SIZE-1:0]  logistic_out,
  output logic                              logistic_valid
);

  // Saturation limits of a Q8.8 word
  localparam logic signed [`NTM_DATA_SIZE-1:0] DATA_MAX = {1'b0, {(`NTM_DATA_SIZE-1){1'b1}}};
  localparam logic signed [`NTM_DATA_SIZE-1:0] DATA_MIN = {1'b1, {(`NTM_DATA_SIZE-1){1'b0}}};

  // Hard sigmoid constants, 1.0 and 0.5 in Q8.8
  localparam logic signed [`NTM_DATA_SIZE:0] SIG_ONE  = 1 << `NTM_FRAC_BITS;
  localparam logic signed [`NTM_DATA_SIZE:0] SIG_HALF = 1 << (`NTM_FRAC_BITS - 1);
  localparam int SIG_SHIFT = 2;

  logic signed [`NTM_ACC_SIZE-1:0]  scaled;
  logic signed [`NTM_DATA_SIZE-1:0] scaled_sat;
  logic signed [`NTM_DATA_SIZE:0]   biased;
  logic signed [`NTM_DATA_SIZE-1:0] z;
  logic signed [`NTM_DATA_SIZE:0]   sigmoid;

  // Back to Q8.8, then clip to one word
  assign scaled = accumulator >>> `NTM_FRAC_BITS;

  always_comb begin
    if (scaled > DATA_MAX) begin
      scaled_sat = DATA_MAX;
    end else if (scaled < DATA_MIN) begin
      scaled_sat = DATA_MIN;
    end else begin
      scaled_sat = scaled[`NTM_DATA_SIZE-1:0];
    end
  end

  // Bias add with one guard bit
  assign biased = scaled_sat + bias;

  always_comb begin
    if (biased > DATA_MAX) begin
      z = DATA_MAX;
    end else if (biased < DATA_MIN) begin
      z = DATA_MIN;
    end else begin
      z = biased[`NTM_DATA_SIZE-1:0];
    end
  end

  // z/4 + 1/2
  assign sigmoid = (z >>> SIG_SHIFT) + SIG_HALF;

  // Result register, clamp to 0..1
  always_ff @(posedge CLK) begin
    if (sigmoid < 0) begin
      logistic_out <= '0;
    end else if (sigmoid > SIG_ONE) begin
      logistic_out <= SIG_ONE[`NTM_DATA_SIZE-1:0];
    end else begin
      logistic_out <= sigmoid[`NTM_DATA_SIZE-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      logistic_valid <= 1'b0;
    end else begin
      logistic_valid <= logistic_start;
    end
  end

endmodule

//--- ntm_dot_product.sv
`timescale 1ns/10ps
`include "ntm_defs.svh"

module ntm_dot_product (
  input  logic                              CLK,
  input  logic                              RST,
  // Control strobes
  input  logic                              mac_clear,
  input  logic                              mac_issue,
  // One matrix element and one vector element per issue
  input  logic signed [`NTM_DATA_SIZE-1:0]  operand_a,
  input  logic signed [`NTM_DATA_SIZE-1:0]  operand_b,
  // Running sum
  output logic signed [`NTM_ACC_SIZE-1:0]   accumulator
);

  localparam int PRODUCT_SIZE = 2 * `NTM_DATA_SIZE;

  // Stage 1 registers
  logic signed [PRODUCT_SIZE-1:0] product;
  logic                           product_valid;

  // Product sign extended to the accumulator
  logic signed [`NTM_ACC_SIZE-1:0] product_ext;

  ////////////////////
  // Stage 1
  ////////////////////

  // Full width signed product
  always_ff @(posedge CLK) begin
    product <= operand_a * operand_b;
  end

  // Marks which products count
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      product_valid <= 1'b0;
    end else begin
      product_valid <= mac_issue;
    end
  end

  ////////////////////
  // Stage 2
  ////////////////////

  assign product_ext = {{(`NTM_ACC_SIZE-PRODUCT_SIZE){product[PRODUCT_SIZE-1]}}, product};

  // Clear wins over a pending add
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      accumulator <= '0;
    end else if (mac_clear) begin
      accumulator <= '0;
    end else if (product_valid) begin
      accumulator <= accumulator + product_ext;
    end
  end

endmodule

//--- ntm_operand_memory.sv
`timescale 1ns/10ps
`include "ntm_defs.svh"

module ntm_operand_memory (
  input  logic                                CLK,
  input  logic                                RST,
  // Host write port
  input  logic                                load_enable,
  input  ntm_pkg::ntm_operand_t               load_select,
  input  logic        [`NTM_INDEX_BITS-1:0]   load_row,
  input  logic        [`NTM_INDEX_BITS-1:0]   load_column,
  input  logic        [`NTM_DATA_SIZE-1:0]    load_data,
  // Matrix read port
  input  ntm_pkg::ntm_operand_t               matrix_select,
  input  logic        [`NTM_INDEX_BITS-1:0]   matrix_row,
  input  logic        [`NTM_INDEX_BITS-1:0]   matrix_column,
  output logic signed [`NTM_DATA_SIZE-1:0]    matrix_data,
  // Vector read port
  input  ntm_pkg::ntm_operand_t               vector_select,
  input  logic        [`NTM_INDEX_BITS-1:0]   vector_index,
  output logic signed [`NTM_DATA_SIZE-1:0]    vector_data,
  // Bias read port
  input  logic        [`NTM_INDEX_BITS-1:0]   bias_index,
  output logic signed [`NTM_DATA_SIZE-1:0]    bias_data
);
  import ntm_pkg::*;

  // Matrices, row major
  logic signed [`NTM_DATA_SIZE-1:0] w_mem [0:`NTM_MAX_L-1][0:`NTM_MAX_X-1];
  logic signed [`NTM_DATA_SIZE-1:0] k_mem [0:`NTM_MAX_L-1][0:`NTM_MAX_W-1];
  logic signed [`NTM_DATA_SIZE-1:0] u_mem [0:`NTM_MAX_L-1][0:`NTM_MAX_L-1];

  // Vectors
  logic signed [`NTM_DATA_SIZE-1:0] x_mem [0:`NTM_MAX_X-1];
  logic signed [`NTM_DATA_SIZE-1:0] r_mem [0:`NTM_MAX_W-1];
  logic signed [`NTM_DATA_SIZE-1:0] h_mem [0:`NTM_MAX_L-1];
  logic signed [`NTM_DATA_SIZE-1:0] b_mem [0:`NTM_MAX_L-1];

  ////////////////////
  // Write side
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < `NTM_MAX_L; i++) begin
        for (int j = 0; j < `NTM_MAX_X; j++) begin
          w_mem[i][j] <= '0;
        end
        for (int j = 0; j < `NTM_MAX_W; j++) begin
          k_mem[i][j] <= '0;
        end
        for (int j = 0; j < `NTM_MAX_L; j++) begin
          u_mem[i][j] <= '0;
        end
        h_mem[i] <= '0;
        b_mem[i] <= '0;
      end
      for (int j = 0; j < `NTM_MAX_X; j++) begin
        x_mem[j] <= '0;
      end
      for (int j = 0; j < `NTM_MAX_W; j++) begin
        r_mem[j] <= '0;
      end
    end else if (load_enable) begin
      // Vectors take the column as their index
      case (load_select)
        OPERAND_W: w_mem[load_row][load_column] <= load_data;
        OPERAND_K: k_mem[load_row][load_column] <= load_data;
        OPERAND_U: u_mem[load_row][load_column] <= load_data;
        OPERAND_X: x_mem[load_column] <= load_data;
        OPERAND_R: r_mem[load_column] <= load_data;
        OPERAND_H: h_mem[load_column] <= load_data;
        OPERAND_B: b_mem[load_column] <= load_data;
        default:   ;
      endcase
    end
  end

  ////////////////////
  // Read side
  ////////////////////

  // Matrix mux, zero when the address falls outside the store
  always_comb begin
    matrix_data = '0;
    case (matrix_select)
      OPERAND_W: if (matrix_column < `NTM_MAX_X) matrix_data = w_mem[matrix_row][matrix_column];
      OPERAND_K: if (matrix_column < `NTM_MAX_W) matrix_data = k_mem[matrix_row][matrix_column];
      OPERAND_U: if (matrix_column < `NTM_MAX_L) matrix_data = u_mem[matrix_row][matrix_column];
      default:   matrix_data = '0;
    endcase
  end

  // Vector mux
  always_comb begin
    vector_data = '0;
    case (vector_select)
      OPERAND_X: if (vector_index < `NTM_MAX_X) vector_data = x_mem[vector_index];
      OPERAND_R: if (vector_index < `NTM_MAX_W) vector_data = r_mem[vector_index];
      OPERAND_H: if (vector_index < `NTM_MAX_L) vector_data = h_mem[vector_index];
      default:   vector_data = '0;
    endcase
  end

  // Bias of the current row
  assign bias_data = (bias_index < `NTM_MAX_L) ? b_mem[bias_index] : '0;

endmodule

//--- ntm_pkg.sv
package ntm_pkg;

  ////////////////////
  // Operand select
  ////////////////////

  // Which store a host write or a read port addresses
  typedef enum logic [2:0] {
    OPERAND_W = 3'd0,
    OPERAND_K = 3'd1,
    OPERAND_U = 3'd2,
    OPERAND_X = 3'd3,
    OPERAND_R = 3'd4,
    OPERAND_H = 3'd5,
    OPERAND_B = 3'd6
  } ntm_operand_t;

  ////////////////////
  // Controller states
  ////////////////////

  typedef enum logic [2:0] {
    STARTER_STATE   = 3'd0,
    W_PRODUCT_STATE = 3'd1,
    K_PRODUCT_STATE = 3'd2,
    U_PRODUCT_STATE = 3'd3,
    DRAIN_STATE     = 3'd4,
    LOGISTIC_STATE  = 3'd5,
    OUTPUT_STATE    = 3'd6,
    ENDER_STATE     = 3'd7
  } ntm_gate_state_t;

endpackage

//--- ntm_defs.svh
`ifndef NTM_DEFS_SVH
`define NTM_DEFS_SVH

////////////////////
// Data path widths
////////////////////

// Q8.8 operands and gate results
`define NTM_DATA_SIZE 16

// Full product plus headroom for up to 24 terms
`define NTM_ACC_SIZE 40

// Fraction bits of the Q8.8 format
`define NTM_FRAC_BITS 8

////////////////////
// Dimensions
////////////////////

// Longest input vector x
`define NTM_MAX_X 8

// Longest read vector r
`define NTM_MAX_W 8

// Most rows of the gate
`define NTM_MAX_L 8

// Row and column addresses
`define NTM_INDEX_BITS 3

// Size ports hold 1 to 8
`define NTM_SIZE_BITS 4

`endif
